/* common/matmul_defines.svh */
// Sizes are fixed at a 4x4 array with 16-bit wrapping data and no runtime size control
`ifndef MATMUL_DEFINES_SVH
`define MATMUL_DEFINES_SVH

// Element and address widths
`define DWIDTH 16
`define AWIDTH 10
`define ADDR_STRIDE_WIDTH 16

// Array dimension N for an N x N multiply
`define MAT_MUL_SIZE 4

// Cycles from an operand entering a PE to its product landing in the accumulator
`define NUM_CYCLES_IN_MAC 3

// Width of the cycle counter in the controller
`define CNT_WIDTH 8

// Count at which every accumulator holds its final value
`define LATCH_COUNT (3*`MAT_MUL_SIZE-1+`NUM_CYCLES_IN_MAC)

// Count at which the multiply reports done, after all columns are out
`define DONE_COUNT (`LATCH_COUNT+`MAT_MUL_SIZE+1)

`endif

/* common/matmul_pkg.sv */
// Types for the 4x4 multiplier; widths come from matmul_defines.svh
`include "matmul_defines.svh"

package matmul_pkg;

  // One matrix element
  typedef logic [`DWIDTH-1:0] data_t;

  // N elements side by side, element i in slice i
  typedef logic [`MAT_MUL_SIZE-1:0][`DWIDTH-1:0] row_t;

  // Address of a C column and the step between columns
  typedef logic [`AWIDTH-1:0] addr_t;
  typedef logic [`ADDR_STRIDE_WIDTH-1:0] stride_t;

  // Cycle counter for one multiply
  typedef logic [`CNT_WIDTH-1:0] cnt_t;

  // Controller states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } ctrl_state_t;

endpackage

/* systolic_array/processing_element.sv */
// Products and sums wrap modulo 2^16; clear wipes the whole pipeline in one cycle
`timescale 1ns/1ns
`include "matmul_defines.svh"

module processing_element import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  data_t in_a,
  input  data_t in_b,
  output data_t out_a,
  output data_t out_b,
  output data_t accum
);

  data_t a_reg;
  data_t b_reg;
  data_t prod;

  // Operand register, product register and accumulator form the MAC pipeline
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      a_reg <= '0;
      b_reg <= '0;
      prod  <= '0;
      accum <= '0;
    end else begin
      a_reg <= in_a;
      b_reg <= in_b;
      prod  <= a_reg * b_reg;
      accum <= accum + prod;
    end
  end

  // The registered operands move on to the right and down
  assign out_a = a_reg;
  assign out_b = b_reg;

  // A cleared cell keeps its accumulator empty until a new product can reach it
  a_clear_empties: assert property (
    @(posedge clk) disable iff (reset)
    clear |=> (accum == '0) [*`NUM_CYCLES_IN_MAC]
  );

endmodule

/* systolic_array/systolic_array.sv */
// Operands must arrive one column of A and one row of B per cycle; zeros keep the sums stable
`timescale 1ns/1ns
`include "matmul_defines.svh"

module systolic_array import matmul_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  row_t  a_col,
  input  row_t  b_row,
  output data_t c_matrix [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1]
);

  // Link j of row i feeds PE(i,j); link N is what leaves the last column
  data_t a_link [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE];
  data_t b_link [0:`MAT_MUL_SIZE][0:`MAT_MUL_SIZE-1];

  ////////////////////////////////////////
  // Input skew
  ////////////////////////////////////////

  // Row i of A and column i of B are held back by i cycles
  for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign a_link[i][0] = a_col[i];
      assign b_link[0][i] = b_row[i];
    end else begin : g_delay
      data_t a_dly [0:i-1];
      data_t b_dly [0:i-1];

      always_ff @(posedge clk) begin
        if (reset || clear) begin
          for (int s = 0; s < i; s++) begin
            a_dly[s] <= '0;
            b_dly[s] <= '0;
          end
        end else begin
          a_dly[0] <= a_col[i];
          b_dly[0] <= b_row[i];
          for (int s = 1; s < i; s++) begin
            a_dly[s] <= a_dly[s-1];
            b_dly[s] <= b_dly[s-1];
          end
        end
      end

      assign a_link[i][0] = a_dly[i-1];
      assign b_link[0][i] = b_dly[i-1];
    end
  end

  ////////////////////////////////////////
  // PE grid
  ////////////////////////////////////////

  for (genvar i = 0; i < `MAT_MUL_SIZE; i++) begin : g_row
    for (genvar j = 0; j < `MAT_MUL_SIZE; j++) begin : g_col
      processing_element u_pe (
        .clk   (clk),
        .reset (reset),
        .clear (clear),
        .in_a  (a_link[i][j]),
        .in_b  (b_link[i][j]),
        .out_a (a_link[i][j+1]),
        .out_b (b_link[i+1][j]),
        .accum (c_matrix[i][j])
      );
    end
  end

endmodule

/* source/matmul_ctrl.sv */
// A new multiply needs start low for a cycle; dropping start mid-run aborts it
`timescale 1ns/1ns
`include "matmul_defines.svh"

module matmul_ctrl import matmul_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic start_mat_mul,
  output cnt_t clk_cnt,
  output logic done_mat_mul,
  output logic running
);

  ctrl_state_t state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IDLE;
      clk_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          clk_cnt <= '0;
          if (start_mat_mul) state <= RUN;
        end
        RUN: begin
          if (!start_mat_mul) begin
            state   <= IDLE;
            clk_cnt <= '0;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
            if (clk_cnt == cnt_t'(`DONE_COUNT - 1)) state <= DONE;
          end
        end
        DONE: begin
          // Hold the final count until the caller lets go of start
          if (!start_mat_mul) begin
            state   <= IDLE;
            clk_cnt <= '0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign done_mat_mul = (state == DONE);

  // Also high on the start edge so the array takes operand 0 on that edge
  assign running = start_mat_mul && (state != DONE);

  a_cnt_bounded: assert property (
    @(posedge clk) disable iff (reset)
    clk_cnt <= cnt_t'(`DONE_COUNT)
  );

endmodule

/* source/output_logic.sv */
// Base and stride must stay stable until the latch; addresses wrap modulo 2^AWIDTH
`timescale 1ns/1ns
`include "matmul_defines.svh"

module output_logic import matmul_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    running,
  input  logic    done_mat_mul,
  input  cnt_t    clk_cnt,
  input  addr_t   address_mat_c,
  input  stride_t address_stride_c,
  input  data_t   c_matrix [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1],
  output row_t    c_data_out,
  output addr_t   c_addr,
  output logic    c_data_available
);

  logic  row_latch_en;
  addr_t stride_step;
  cnt_t  col_cnt;
  row_t  c_col [0:`MAT_MUL_SIZE-1];
  // Columns 1 to N-1 wait here behind c_data_out
  row_t  c_pend [1:`MAT_MUL_SIZE-1];

  // Only the low address bits of the stride matter after wrapping
  assign stride_step = addr_t'(address_stride_c);

  assign row_latch_en = (clk_cnt == cnt_t'(`LATCH_COUNT));

  // Gather column j of C with element i in slice i
  always_comb begin
    for (int j = 0; j < `MAT_MUL_SIZE; j++) begin
      for (int i = 0; i < `MAT_MUL_SIZE; i++) begin
        c_col[j][i] = c_matrix[i][j];
      end
    end
  end

  ////////////////////////////////////////
  // Latch and shift out
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || !running || done_mat_mul) begin
      c_data_available <= 1'b0;
      c_addr           <= address_mat_c + stride_step;
      c_data_out       <= '0;
      col_cnt          <= '0;
      for (int k = 1; k < `MAT_MUL_SIZE; k++) begin
        c_pend[k] <= '0;
      end
    end else if (row_latch_en) begin
      c_data_available <= 1'b1;
      c_addr           <= c_addr - stride_step;
      c_data_out       <= c_col[0];
      col_cnt          <= cnt_t'(1);
      for (int k = 1; k < `MAT_MUL_SIZE; k++) begin
        c_pend[k] <= c_col[k];
      end
    end else if (c_data_available) begin
      if (col_cnt == cnt_t'(`MAT_MUL_SIZE)) begin
        c_data_available <= 1'b0;
      end else begin
        c_addr     <= c_addr - stride_step;
        c_data_out <= c_pend[1];
        col_cnt    <= col_cnt + 1'b1;
        for (int k = 1; k < `MAT_MUL_SIZE - 1; k++) begin
          c_pend[k] <= c_pend[k+1];
        end
        // Zeros fill in behind the last column
        c_pend[`MAT_MUL_SIZE-1] <= '0;
      end
    end else begin
      // Follow the base while waiting so the first column lands on it
      c_addr <= address_mat_c + stride_step;
    end
  end

  a_avail_len: assert property (
    @(posedge clk) disable iff (reset)
    $rose(c_data_available) |-> ##(`MAT_MUL_SIZE) !c_data_available
  );

endmodule

/* source/matmul_top.sv */
// One 4x4 multiply per start pulse train; results stream out as columns with no back-pressure
`timescale 1ns/1ns
`include "matmul_defines.svh"

module matmul_top import matmul_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    start_mat_mul,
  input  row_t    a_col,
  input  row_t    b_row,
  input  addr_t   address_mat_c,
  input  stride_t address_stride_c,
  output row_t    c_data_out,
  output addr_t   c_addr,
  output logic    c_data_available,
  output logic    done_mat_mul
);

  cnt_t  clk_cnt;
  logic  running;
  data_t c_matrix [0:`MAT_MUL_SIZE-1][0:`MAT_MUL_SIZE-1];

  matmul_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .clk_cnt       (clk_cnt),
    .done_mat_mul  (done_mat_mul),
    .running       (running)
  );

  // The array empties itself whenever no multiply is in progress
  systolic_array u_array (
    .clk      (clk),
    .reset    (reset),
    .clear    (!running),
    .a_col    (a_col),
    .b_row    (b_row),
    .c_matrix (c_matrix)
  );

  output_logic u_out (
    .clk              (clk),
    .reset            (reset),
    .running          (running),
    .done_mat_mul     (done_mat_mul),
    .clk_cnt          (clk_cnt),
    .address_mat_c    (address_mat_c),
    .address_stride_c (address_stride_c),
    .c_matrix         (c_matrix),
    .c_data_out       (c_data_out),
    .c_addr           (c_addr),
    .c_data_available (c_data_available)
  );

endmodule

/* tb/matmul_tb.sv */
// Runs every table entry back to back through matmul_top; sizes come from the fixed defines only
`timescale 1ns/1ns
`include "matmul_defines.svh"

module matmul_tb import matmul_pkg::*; ();

  localparam int N            = `MAT_MUL_SIZE;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_FIXED    = 4;
  localparam int NUM_ENTRIES  = 8;
  localparam int FIRST_OUT    = `LATCH_COUNT + 1;
  localparam int WATCHDOG_NS  = NUM_ENTRIES * (`DONE_COUNT + 10) * CLK_PERIOD
                                + RESET_CYCLES * CLK_PERIOD;

  logic    clk;
  logic    reset;
  logic    start_mat_mul;
  row_t    a_col;
  row_t    b_row;
  addr_t   address_mat_c;
  stride_t address_stride_c;
  row_t    c_data_out;
  addr_t   c_addr;
  logic    c_data_available;
  logic    done_mat_mul;

  // Stimulus table with A, B, base and stride per entry
  data_t   tab_a [0:NUM_ENTRIES-1][0:N-1][0:N-1];
  data_t   tab_b [0:NUM_ENTRIES-1][0:N-1][0:N-1];
  addr_t   tab_base [0:NUM_ENTRIES-1];
  stride_t tab_stride [0:NUM_ENTRIES-1];

  data_t   exp_c [0:N-1][0:N-1];
  integer  seed;
  int      error_count;

  matmul_top uut (
    .clk              (clk),
    .reset            (reset),
    .start_mat_mul    (start_mat_mul),
    .a_col            (a_col),
    .b_row            (b_row),
    .address_mat_c    (address_mat_c),
    .address_stride_c (address_stride_c),
    .c_data_out       (c_data_out),
    .c_addr           (c_addr),
    .c_data_available (c_data_available),
    .done_mat_mul     (done_mat_mul)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Test failed");
      $fatal(1, "stopped at the first error");
    end
  endtask

  // Column k of A enters in input cycle k, element i in slice i
  function automatic row_t a_column_of(input int e, input int k);
    row_t col;
    for (int i = 0; i < N; i++) begin
      col[i] = tab_a[e][i][k];
    end
    return col;
  endfunction

  function automatic row_t b_row_of(input int e, input int k);
    row_t row;
    for (int j = 0; j < N; j++) begin
      row[j] = tab_b[e][k][j];
    end
    return row;
  endfunction

  // Address of output column j counts down from the base and wraps to AWIDTH bits
  function automatic addr_t expected_addr(input int e, input int j);
    logic [31:0] full;
    full = 32'(tab_base[e]) - 32'(j) * 32'(tab_stride[e]);
    return full[`AWIDTH-1:0];
  endfunction

  // Plain 16-bit wrapping matrix product
  task automatic compute_expected(input int e);
    data_t acc;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        acc = '0;
        for (int k = 0; k < N; k++) begin
          acc = acc + tab_a[e][i][k] * tab_b[e][k][j];
        end
        exp_c[i][j] = acc;
      end
    end
  endtask

  task automatic build_table();
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        // Identity times a ramp gives the ramp back
        tab_a[0][i][j] = (i == j) ? 16'h0001 : 16'h0000;
        tab_b[0][i][j] = data_t'(16'h0101 * (i * N + j + 1));
        tab_a[1][i][j] = 16'h0001;
        tab_b[1][i][j] = 16'h0001;
        // Largest values, so every product and sum wraps
        tab_a[2][i][j] = 16'hffff;
        tab_b[2][i][j] = data_t'(16'hffff - (i * N + j));
        tab_a[3][i][j] = data_t'(16'h7ff0 + i * N + j);
        tab_b[3][i][j] = data_t'(16'h8003 * (j + 1) + i);
      end
    end
    tab_base[0]   = 10'h100;
    tab_stride[0] = 16'h0010;
    // Small base with a stride that underflows below zero
    tab_base[1]   = 10'h002;
    tab_stride[1] = 16'h0003;
    // Stride wider than the address, only its low bits count
    tab_base[2]   = 10'h3ff;
    tab_stride[2] = 16'hfc01;
    tab_base[3]   = 10'h155;
    tab_stride[3] = 16'h0000;
    for (int e = NUM_FIXED; e < NUM_ENTRIES; e++) begin
      for (int i = 0; i < N; i++) begin
        for (int j = 0; j < N; j++) begin
          tab_a[e][i][j] = data_t'($random(seed));
          tab_b[e][i][j] = data_t'($random(seed));
        end
      end
      tab_base[e]   = addr_t'($random(seed));
      tab_stride[e] = stride_t'($random(seed));
    end
  endtask

  ////////////////////////////////////////
  // One multiply
  ////////////////////////////////////////

  task automatic run_entry(input int e);
    int   n;
    int   out_idx;
    logic expect_avail;
    logic done_seen;
    // The DUT sees start low on this edge, operand 0 goes with the rising start
    @(posedge clk);
    start_mat_mul    <= 1'b1;
    a_col            <= a_column_of(e, 0);
    b_row            <= b_row_of(e, 0);
    address_mat_c    <= tab_base[e];
    address_stride_c <= tab_stride[e];
    @(negedge clk);
    check_value("c_data_available", c_data_available, 1'b0);
    check_value("done_mat_mul", done_mat_mul, 1'b0);
    n = 0;
    out_idx = 0;
    done_seen = 1'b0;
    // n counts edges from the first one that sees start high
    while (!done_seen) begin
      @(posedge clk);
      if (n + 1 < N) begin
        a_col <= a_column_of(e, n + 1);
        b_row <= b_row_of(e, n + 1);
      end else begin
        a_col <= '0;
        b_row <= '0;
      end
      @(negedge clk);
      expect_avail = (n >= FIRST_OUT) && (n < FIRST_OUT + N);
      check_value("c_data_available", c_data_available, expect_avail);
      check_value("done_mat_mul", done_mat_mul, n >= `DONE_COUNT);
      if (c_data_available) begin
        for (int i = 0; i < N; i++) begin
          check_value($sformatf("c_data_out[%0d]", i), c_data_out[i], exp_c[i][out_idx]);
        end
        check_value("c_addr", c_addr, expected_addr(e, out_idx));
        out_idx++;
      end
      done_seen = done_mat_mul;
      n++;
    end
    // done holds while start stays high
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_value("done_mat_mul", done_mat_mul, 1'b1);
      check_value("c_data_available", c_data_available, 1'b0);
    end
    @(posedge clk);
    start_mat_mul <= 1'b0;
    @(negedge clk);
    check_value("done_mat_mul", done_mat_mul, 1'b1);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    reset            = 1'b1;
    start_mat_mul    = 1'b0;
    a_col            = '0;
    b_row            = '0;
    address_mat_c    = '0;
    address_stride_c = '0;
    error_count      = 0;
    seed             = 32'h1ceb_f3a0;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("c_data_available", c_data_available, 1'b0);
    check_value("done_mat_mul", done_mat_mul, 1'b0);
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      compute_expected(e);
      run_entry(e);
    end
    // Once start is low the controller is back in IDLE
    @(posedge clk);
    @(negedge clk);
    check_value("done_mat_mul", done_mat_mul, 1'b0);
    check_value("c_data_available", c_data_available, 1'b0);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before all multiplies finished", WATCHDOG_NS);
    $display("Test failed");
    $fatal(1, "timeout");
  end

endmodule

/* flist.f */
+incdir+common
common/matmul_pkg.sv
systolic_array/processing_element.sv
systolic_array/systolic_array.sv
source/matmul_ctrl.sv
source/output_logic.sv
source/matmul_top.sv
tb/matmul_tb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = matmul_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = Test completed successfully

.PHONY: lint build sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The run passes only if the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
